/* dmem_array.sv */
////////////////////
// 64-bit word storage, no reset, read is combinational
// a read and write to one address in a cycle returns the old word
////////////////////
`timescale 1ns/10ps
module dmem_array #(
  parameter int ADDR_W = 8
) (
  input  logic              clock,
  input  logic              arr_we,
  input  logic [ADDR_W-1:0] arr_waddr,
  input  logic [63:0]       arr_wdata,
  input  logic [ADDR_W-1:0] arr_raddr,
  output logic [63:0]       arr_rdata
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [63:0] mem [DEPTH];  // swap for a RAM macro here

  // single write port
  always_ff @(posedge clock) begin
    if (arr_we) begin
      mem[arr_waddr] <= arr_wdata;
    end
  end

  // single async read port
  assign arr_rdata = mem[arr_raddr];

endmodule

/* dmem_pipe.sv */
////////////////////
// fixed latency data memory front end, every non-idle command is taken
// MEM_LATENCY must stay in 1..14 so a tag is never reused while in flight
////////////////////
`timescale 1ns/10ps
module dmem_pipe #(
  parameter int MEM_LATENCY = 4,
  parameter int ADDR_W      = 8
) (
  input  logic                      clock,
  input  logic                      reset,
  input  mem_pkg::bus_cmd_t         dmem_command,
  input  logic [63:0]               dmem_addr,     // byte address
  input  logic [63:0]               dmem_wdata,
  output logic [mem_pkg::TAG_W-1:0] dmem_response,
  output logic [mem_pkg::TAG_W-1:0] dmem_tag,
  output logic [63:0]               dmem_rdata,
  // storage side
  output logic                      arr_we,
  output logic [ADDR_W-1:0]         arr_waddr,
  output logic [63:0]               arr_wdata,
  output logic [ADDR_W-1:0]         arr_raddr,
  input  logic [63:0]               arr_rdata
);

  localparam int LAST = MEM_LATENCY - 1;

  logic                      accept;
  logic [mem_pkg::TAG_W-1:0] next_tag;   // round robin over 1..15

  // pipe slots, index 0 is the newest
  logic [MEM_LATENCY-1:0]    slot_valid;
  mem_pkg::bus_cmd_t         slot_cmd  [MEM_LATENCY];
  logic [mem_pkg::TAG_W-1:0] slot_tag  [MEM_LATENCY];
  logic [ADDR_W-1:0]         slot_addr [MEM_LATENCY];
  logic [63:0]               slot_data [MEM_LATENCY];

  logic last_load;
  logic last_store;

  assign accept        = (dmem_command != mem_pkg::BUS_NONE);
  assign dmem_response = accept ? next_tag : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      next_tag <= 1;
    end else if (accept) begin
      next_tag <= (next_tag == '1) ? 1 : next_tag + 1'b1;  // skip tag 0
    end
  end

  ////////////////////
  // shift pipe
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      slot_valid <= '0;
    end else begin
      slot_valid[0] <= accept;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        slot_valid[i] <= slot_valid[i-1];
      end
    end
  end

  // payload only means something where slot_valid is set
  always_ff @(posedge clock) begin
    slot_cmd[0]  <= dmem_command;
    slot_tag[0]  <= next_tag;
    slot_addr[0] <= dmem_addr[ADDR_W+2:3];  // word address
    slot_data[0] <= dmem_wdata;
    for (int i = 1; i < MEM_LATENCY; i++) begin
      slot_cmd[i]  <= slot_cmd[i-1];
      slot_tag[i]  <= slot_tag[i-1];
      slot_addr[i] <= slot_addr[i-1];
      slot_data[i] <= slot_data[i-1];
    end
  end

  ////////////////////
  // last slot, touches the array
  ////////////////////
  assign last_load  = slot_valid[LAST] && (slot_cmd[LAST] == mem_pkg::BUS_LOAD);
  assign last_store = slot_valid[LAST] && (slot_cmd[LAST] == mem_pkg::BUS_STORE);

  assign arr_we     = last_store;        // write lands at the end of this cycle
  assign arr_waddr  = slot_addr[LAST];
  assign arr_wdata  = slot_data[LAST];
  assign arr_raddr  = slot_addr[LAST];

  assign dmem_tag   = slot_valid[LAST] ? slot_tag[LAST] : '0;  // one cycle pulse per slot
  assign dmem_rdata = last_load ? arr_rdata : '0;

endmodule

/* mem_pkg.sv */
////////////////////
// shared bus and operation encodings for the data memory subsystem
// tag 0 is reserved to mean "no tag", so TAG_W bits give 2**TAG_W-1 live tags
////////////////////
package mem_pkg;

  // width of the memory bus tag / response fields
  localparam int TAG_W = 4;

  // command on the data memory bus
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,  // idle bus
    BUS_LOAD  = 2'h1,  // read one 64-bit word
    BUS_STORE = 2'h2   // write one 64-bit word
  } bus_cmd_t;

  // operation class handed over from EX
  typedef enum logic [1:0] {
    OP_ALU   = 2'h0,  // result passes straight through
    OP_LOAD  = 2'h1,  // result is the loaded word
    OP_STORE = 2'h2   // posted write, result is the address
  } mem_op_t;

endpackage

/* mem_stage.sv */
////////////////////
// memory access stage, one load in flight, stores posted
// EX must hold in_op/in_addr/in_data while in_valid is high and in_ready low
////////////////////
`timescale 1ns/10ps
module mem_stage (
  input  logic                      clock,
  input  logic                      reset,
  // upstream from EX
  input  logic                      in_valid,
  output logic                      in_ready,
  input  mem_pkg::mem_op_t          in_op,
  input  logic [63:0]               in_addr,        // ALU result, also byte address
  input  logic [63:0]               in_data,        // store data
  // downstream to WB
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [63:0]               out_result,
  // data memory bus
  output mem_pkg::bus_cmd_t         dmem_command,
  output logic [63:0]               dmem_addr,
  output logic [63:0]               dmem_wdata,
  input  logic [mem_pkg::TAG_W-1:0] dmem_response,  // nonzero = command taken
  input  logic [mem_pkg::TAG_W-1:0] dmem_tag,       // completing slot tag
  input  logic [63:0]               dmem_rdata
);

  typedef enum logic [1:0] {
    ST_IDLE = 2'h0,  // free to issue
    ST_WAIT = 2'h1,  // load out, waiting for its tag
    ST_HOLD = 2'h2   // load data parked, downstream stalled
  } state_t;

  state_t                      state;
  logic [mem_pkg::TAG_W-1:0]   waiting_tag;   // tag of the outstanding load
  logic [63:0]                 hold_data;     // parked load result

  logic is_load;
  logic is_store;
  logic can_issue;
  logic accepted;
  logic tag_hit;

  ////////////////////
  // command issue
  ////////////////////
  assign is_load   = (in_op == mem_pkg::OP_LOAD);
  assign is_store  = (in_op == mem_pkg::OP_STORE);
  assign can_issue = in_valid && (state == ST_IDLE);  // nothing pending, nothing held

  always_comb begin
    dmem_command = mem_pkg::BUS_NONE;
    if (can_issue && is_load) begin
      dmem_command = mem_pkg::BUS_LOAD;
    end else if (can_issue && is_store && out_ready) begin
      dmem_command = mem_pkg::BUS_STORE;  // store only when it can retire now
    end
  end

  assign dmem_addr  = in_addr;   // address comes from the ALU
  assign dmem_wdata = in_data;

  // memory may refuse with a zero response, command is then repeated
  assign accepted = (dmem_command != mem_pkg::BUS_NONE) && (dmem_response != '0);

  // our load has come back
  assign tag_hit = (state == ST_WAIT) && (dmem_tag != '0) && (dmem_tag == waiting_tag);

  ////////////////////
  // result side
  ////////////////////
  always_comb begin
    out_valid  = 1'b0;
    out_result = in_addr;               // alu and store pass the address
    case (state)
      ST_IDLE: begin
        if (in_valid && !is_load && !is_store) begin
          out_valid = 1'b1;             // alu op, same cycle
        end else if (is_store) begin
          out_valid = accepted;         // store retires on its response
        end
      end
      ST_WAIT: begin
        out_valid  = tag_hit;
        out_result = dmem_rdata;        // forward straight from the memory
      end
      ST_HOLD: begin
        out_valid  = 1'b1;
        out_result = hold_data;
      end
      default: begin
        out_valid = 1'b0;
      end
    endcase
  end

  // the op leaves EX exactly when its result is taken
  assign in_ready = out_valid && out_ready;

  ////////////////////
  // state
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= ST_IDLE;
      waiting_tag <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accepted && is_load) begin
            waiting_tag <= dmem_response;  // remember which tag to watch for
            state       <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (tag_hit) begin
            waiting_tag <= '0;
            state       <= out_ready ? ST_IDLE : ST_HOLD;
          end
        end
        ST_HOLD: begin
          if (out_ready) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // park the load word when downstream is stalled on its return
  always_ff @(posedge clock) begin
    if (tag_hit && !out_ready) hold_data <= dmem_rdata;
  end

endmodule

/* mem_subsys.sv */
////////////////////
// MEM stage plus tagged data memory, 256 words by default
// load result appears MEM_LATENCY cycles after the load is presented
////////////////////
`timescale 1ns/10ps
module mem_subsys #(
  parameter int MEM_LATENCY = 4,  // 1..14
  parameter int ADDR_W      = 8
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             in_valid,
  output logic             in_ready,
  input  mem_pkg::mem_op_t in_op,
  input  logic [63:0]      in_addr,
  input  logic [63:0]      in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [63:0]      out_result
);

  // stage <-> memory bus
  mem_pkg::bus_cmd_t         dmem_command;
  logic [63:0]               dmem_addr;
  logic [63:0]               dmem_wdata;
  logic [mem_pkg::TAG_W-1:0] dmem_response;
  logic [mem_pkg::TAG_W-1:0] dmem_tag;
  logic [63:0]               dmem_rdata;

  // pipe <-> storage
  logic                      arr_we;
  logic [ADDR_W-1:0]         arr_waddr;
  logic [63:0]               arr_wdata;
  logic [ADDR_W-1:0]         arr_raddr;
  logic [63:0]               arr_rdata;

  mem_stage u_stage (
    .clock        (clock),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_op        (in_op),
    .in_addr      (in_addr),
    .in_data      (in_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_result   (out_result),
    .dmem_command (dmem_command),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_response(dmem_response),
    .dmem_tag     (dmem_tag),
    .dmem_rdata   (dmem_rdata)
  );

  dmem_pipe #(
    .MEM_LATENCY(MEM_LATENCY),
    .ADDR_W     (ADDR_W)
  ) u_pipe (
    .clock        (clock),
    .reset        (reset),
    .dmem_command (dmem_command),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_response(dmem_response),
    .dmem_tag     (dmem_tag),
    .dmem_rdata   (dmem_rdata),
    .arr_we       (arr_we),
    .arr_waddr    (arr_waddr),
    .arr_wdata    (arr_wdata),
    .arr_raddr    (arr_raddr),
    .arr_rdata    (arr_rdata)
  );

  dmem_array #(
    .ADDR_W(ADDR_W)
  ) u_array (
    .clock    (clock),
    .arr_we   (arr_we),
    .arr_waddr(arr_waddr),
    .arr_wdata(arr_wdata),
    .arr_raddr(arr_raddr),
    .arr_rdata(arr_rdata)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_mem_subsys \
  --Mdir obj_dir -o sim_tb &&
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "PASS: all tests" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* sources.f */
mem_pkg.sv
dmem_array.sv
dmem_pipe.sv
mem_stage.sv
mem_subsys.sv
tb_clock.sv
tb_mem_subsys.sv

/* tb_clock.sv */
////////////////////
// testbench clock and reset, reset drops 1 ns after the last reset edge
////////////////////
`timescale 1ns/10ps
module tb_clock #(
  parameter int PERIOD       = 10,  // ns
  parameter int RESET_CYCLES = 5
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 reset = 1'b0;                // same drive point as the stimulus
  end

endmodule

/* tb_mem_subsys.sv */
////////////////////
// directed tests for mem_subsys with inputs driven 1 ns after the rising edge
// outputs sampled on the falling edge and memory ops use aligned word addresses
////////////////////
`timescale 1ns/10ps
module tb_mem_subsys;

  localparam int MEM_LATENCY = 4;
  localparam int ADDR_W      = 8;
  localparam int N_RANDOM    = 200;
  localparam int MAX_CYCLES  = (N_RANDOM + 50) * 16;  // worst case cycles per op with stalls

  logic clock, reset;
  logic in_valid, in_ready, out_valid, out_ready;
  mem_pkg::mem_op_t in_op;
  logic [63:0] in_addr, in_data, out_result;

  logic [63:0] ref_mem [2**ADDR_W];  // reference memory updated on each store handshake
  bit          written [2**ADDR_W];  // words that hold a known value
  logic [31:0] rng_state = 32'hbdfd;
  int errors = 0;
  int checks = 0;
  int cycle_count = 0;

  tb_clock #(.PERIOD(10), .RESET_CYCLES(5)) u_clock (.clock(clock), .reset(reset));

  mem_subsys #(.MEM_LATENCY(MEM_LATENCY), .ADDR_W(ADDR_W)) DUT (
    .clock(clock), .reset(reset),
    .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
    .in_addr(in_addr), .in_data(in_data),
    .out_valid(out_valid), .out_ready(out_ready), .out_result(out_result)
  );

  // xorshift32 stepped once per call
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  ////////////////////
  // one op through the handshake from one drive point to the next
  ////////////////////
  task automatic run_op(input mem_pkg::mem_op_t op, input logic [63:0] addr,
                        input logic [63:0] data, input bit rand_ready, output int lat);
    logic [63:0]       expected;
    logic [ADDR_W-1:0] idx;
    logic [31:0]       r;
    bit                done;
    bit                exp_valid;
    idx      = addr[ADDR_W+2:3];
    in_valid = 1'b1;
    in_op    = op;
    in_addr  = addr;
    in_data  = data;
    lat      = 0;
    done     = 1'b0;
    while (!done) begin
      if (rand_ready) begin
        r         = next_random();
        out_ready = (r[1:0] != 2'b00);  // ready about 3 cycles in 4
      end
      @(negedge clock);
      checks++;
      if (op == mem_pkg::OP_LOAD) begin
        exp_valid = (lat >= MEM_LATENCY);  // held after its return until taken
      end else if (op == mem_pkg::OP_STORE) begin
        exp_valid = out_ready;             // store issues only when it can retire
      end else begin
        exp_valid = 1'b1;
      end
      if (out_valid !== exp_valid) begin
        errors++;
        $display("[FAIL] out_valid expected %h got %h", exp_valid, out_valid);
      end
      if (in_ready !== (exp_valid && out_ready)) begin
        errors++;
        $display("[FAIL] in_ready expected %h got %h", exp_valid && out_ready, in_ready);
      end
      if (out_valid && out_ready) begin
        expected = (op == mem_pkg::OP_LOAD) ? ref_mem[idx] : addr;
        if (out_result !== expected) begin
          errors++;
          $display("[FAIL] out_result expected %h got %h", expected, out_result);
        end
        if (op == mem_pkg::OP_STORE) begin
          ref_mem[idx] = data;  // store is visible to any later load
          written[idx] = 1'b1;
        end
        done = 1'b1;
      end
      @(posedge clock);
      #1;
      if (!done) lat++;
    end
    in_valid = 1'b0;
  endtask

  ////////////////////
  // directed tests
  ////////////////////
  task automatic test_reset();
    @(negedge clock);
    while (reset) begin
      if (out_valid !== 1'b0 || in_ready !== 1'b0) begin
        errors++;
        $display("[FAIL] out_valid/in_ready expected 0/0 got %h/%h in reset",
                 out_valid, in_ready);
      end
      @(negedge clock);
    end
    if (out_valid !== 1'b0 || in_ready !== 1'b0) begin  // first cycle out of reset
      errors++;
      $display("[FAIL] out_valid/in_ready expected 0/0 got %h/%h after reset",
               out_valid, in_ready);
    end
    @(posedge clock);
    #1;
  endtask

  task automatic test_alu();
    int lat;
    run_op(mem_pkg::OP_ALU, 64'hdead_beef_1234_5678, 64'h0, 1'b0, lat);
    if (lat != 0) begin
      errors++;
      $display("alu op took %0d cycles instead of completing at once", lat);
    end
  endtask

  task automatic test_store_load();
    int lat;
    run_op(mem_pkg::OP_STORE, 64'h40, 64'h0123_4567_89ab_cdef, 1'b0, lat);
    run_op(mem_pkg::OP_LOAD, 64'h40, 64'h0, 1'b0, lat);
    if (lat != MEM_LATENCY) begin
      errors++;
      $display("load returned after %0d cycles, expected %0d", lat, MEM_LATENCY);
    end
  endtask

  task automatic test_posted_stores();
    int          k;
    int          lat;
    logic [63:0] a;
    for (k = 0; k < 6; k++) begin
      a = 64'h100 + 64'(k) * 8;     // words 32 to 37
      run_op(mem_pkg::OP_STORE, a, {32'hc0de_0000 | 32'(k), a[31:0] ^ 32'h5a5a_5a5a}, 1'b0, lat);
      if (lat != 0) begin
        errors++;
        $display("store %0d waited %0d cycles before its handshake", k, lat);
      end
    end
    // newest first, so the first load follows a store still in the pipe
    for (k = 5; k >= 0; k--) begin
      run_op(mem_pkg::OP_LOAD, 64'h100 + 64'(k) * 8, 64'h0, 1'b0, lat);
    end
  endtask

  task automatic test_backpressure();
    logic [63:0] expected;
    int          lat;
    int          i;
    expected  = ref_mem[8];         // word at 0x40 from the store/load test
    out_ready = 1'b0;
    in_valid  = 1'b1;
    in_op     = mem_pkg::OP_LOAD;
    in_addr   = 64'h40;
    in_data   = 64'h0;
    lat       = 0;
    @(negedge clock);
    while (out_valid !== 1'b1) begin
      @(posedge clock);
      #1;
      lat++;
      @(negedge clock);
    end
    if (lat != MEM_LATENCY) begin
      errors++;
      $display("stalled load returned after %0d cycles, expected %0d", lat, MEM_LATENCY);
    end
    for (i = 0; i < 4; i++) begin  // return cycle plus three held cycles
      if (i > 0) @(negedge clock);
      checks++;
      if (out_valid !== 1'b1 || in_ready !== 1'b0) begin
        errors++;
        $display("[FAIL] out_valid/in_ready expected 1/0 got %h/%h", out_valid, in_ready);
      end
      if (out_result !== expected) begin
        errors++;
        $display("[FAIL] out_result expected %h got %h", expected, out_result);
      end
    end
    @(posedge clock);
    #1;
    out_ready = 1'b1;
    @(negedge clock);
    if (out_valid !== 1'b1 || in_ready !== 1'b1 || out_result !== expected) begin
      errors++;
      $display("[FAIL] release out_valid/in_ready/out_result expected 1/1/%h got %h/%h/%h",
               expected, out_valid, in_ready, out_result);
    end
    @(posedge clock);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic test_random_mix(input int count);
    int                n;
    int                lat;
    logic [31:0]       r;
    logic [ADDR_W-1:0] idx;
    logic [63:0]       addr;
    logic [63:0]       data;
    mem_pkg::mem_op_t  op;
    for (n = 0; n < count; n++) begin
      r   = next_random();
      idx = {3'b000, r[12:8]};      // words 0 to 31 so loads hit earlier stores
      case (r[1:0])
        2'd0:    op = mem_pkg::OP_ALU;
        2'd1:    op = mem_pkg::OP_LOAD;
        2'd2:    op = mem_pkg::OP_STORE;
        default: op = mem_pkg::OP_LOAD;
      endcase
      if (op == mem_pkg::OP_LOAD && !written[idx]) op = mem_pkg::OP_STORE;  // no unknown words
      data = {next_random(), next_random()};
      if (op == mem_pkg::OP_ALU) addr = {next_random(), next_random()};
      else addr = {{(61 - ADDR_W){1'b0}}, idx, 3'b000};
      run_op(op, addr, data, 1'b1, lat);
    end
    out_ready = 1'b1;
  endtask

  ////////////////////
  // timeout and main sequence
  ////////////////////
  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_count);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    in_valid  = 1'b0;
    in_op     = mem_pkg::OP_ALU;
    in_addr   = 64'h0;
    in_data   = 64'h0;
    out_ready = 1'b1;
    test_reset();
    test_alu();
    test_store_load();
    test_posted_stores();
    test_backpressure();
    test_random_mix(N_RANDOM);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
